/* design/rename_pkg.sv */
package rename_pkg;

    // architectural register count, fixed by the ISA
    localparam int ARCH_REGS = 32;

    // architectural register index
    typedef logic [4:0] arch_reg_t;

    // state of one reorder buffer entry
    typedef enum logic [1:0] {
        // slot holds no instruction
        ROB_FREE       = 2'd0,
        // dispatched, waiting for execution
        ROB_ISSUED     = 2'd1,
        // executed, ready to retire
        ROB_DONE       = 2'd2,
        // executed branch that was mispredicted
        ROB_MISPREDICT = 2'd3
    } rob_state_t;

endpackage

/* design/rename_if.sv */
`timescale 1ns/1ps

interface rename_if import rename_pkg::*; #(
    parameter int PHY_REGS = 64
) ();

    localparam int PHY_W = $clog2(PHY_REGS);

    // lookups, answered combinationally
    arch_reg_t        rs1_arch;
    arch_reg_t        rs2_arch;
    arch_reg_t        rd_arch;
    logic [PHY_W-1:0] rs1_phy;
    logic [PHY_W-1:0] rs2_phy;
    logic [PHY_W-1:0] rd_phy_old;

    // new mapping for rd_arch
    logic             rat_we;
    logic [PHY_W-1:0] rd_phy_new;

    modport stage (
        output rs1_arch, rs2_arch, rd_arch, rat_we, rd_phy_new,
        input  rs1_phy, rs2_phy, rd_phy_old
    );

    modport rat (
        input  rs1_arch, rs2_arch, rd_arch, rat_we, rd_phy_new,
        output rs1_phy, rs2_phy, rd_phy_old
    );

endinterface

/* design/retire_if.sv */
`timescale 1ns/1ps

interface retire_if import rename_pkg::*; #(
    parameter int PHY_REGS = 64
) ();

    localparam int PHY_W = $clog2(PHY_REGS);

    // one-cycle pulses from the ROB
    logic             retire_valid;
    logic             retire_has_rd;
    arch_reg_t        retire_rd_arch;
    logic [PHY_W-1:0] retire_phy_new;
    logic [PHY_W-1:0] retire_phy_old;
    logic             flush;

    modport rob (
        output retire_valid, retire_has_rd, retire_rd_arch,
        output retire_phy_new, retire_phy_old, flush
    );

    modport sink (
        input retire_valid, retire_has_rd, retire_rd_arch,
        input retire_phy_new, retire_phy_old, flush
    );

endinterface

/* design/front_rat.sv */
`timescale 1ns/1ps

module front_rat import rename_pkg::*; #(
    parameter int PHY_REGS = 64
) (
    input  logic                                 clk,
    input  logic                                 rst,
    rename_if.rat                                rat,
    retire_if.sink                               ret,
    input  logic [ARCH_REGS*$clog2(PHY_REGS)-1:0] back_table
);

    localparam int PHY_W = $clog2(PHY_REGS);

    // speculative map
    logic [PHY_W-1:0] map [ARCH_REGS];

    // lookups see the map before this edge's write
    assign rat.rs1_phy    = map[rat.rs1_arch];
    assign rat.rs2_phy    = map[rat.rs2_arch];
    assign rat.rd_phy_old = map[rat.rd_arch];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= PHY_W'(i);
            end
        end else if (ret.flush) begin
            // restore from the retired map
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= back_table[i*PHY_W +: PHY_W];
            end
            // back table is one edge late for the mispredicted entry itself
            if (ret.retire_valid && ret.retire_has_rd) begin
                map[ret.retire_rd_arch] <= ret.retire_phy_new;
            end
        end else if (rat.rat_we) begin
            map[rat.rd_arch] <= rat.rd_phy_new;
        end
    end

endmodule

/* design/free_list.sv */
`timescale 1ns/1ps

module free_list import rename_pkg::*; #(
    parameter int PHY_REGS = 64
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        alloc,
    output logic [$clog2(PHY_REGS)-1:0] alloc_phy,
    output logic                        empty,
    retire_if.sink                      ret
);

    localparam int PHY_W = $clog2(PHY_REGS);

    // never more than PHY_REGS-ARCH_REGS entries, so the queue cannot fill
    logic [PHY_W-1:0] queue [PHY_REGS];

    logic [PHY_W-1:0] tail;
    logic [PHY_W-1:0] spec_head;
    logic [PHY_W-1:0] ret_head;
    logic [PHY_W-1:0] ret_head_next;
    logic [PHY_W-1:0] free_count;
    logic             retire_push;

    assign retire_push = ret.retire_valid && ret.retire_has_rd;

    // retired head moves once per retired destination
    assign ret_head_next = retire_push ? ret_head + 1'b1 : ret_head;

    // registers still available to rename
    assign free_count = tail - spec_head;
    assign empty      = (free_count == '0);
    assign alloc_phy  = queue[spec_head];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // ARCH_REGS .. PHY_REGS-1 free in ascending order
            for (int i = 0; i < PHY_REGS; i++) begin
                queue[i] <= PHY_W'(ARCH_REGS + i);
            end
            tail      <= PHY_W'(PHY_REGS - ARCH_REGS);
            spec_head <= '0;
            ret_head  <= '0;
        end else begin
            if (retire_push) begin
                queue[tail] <= ret.retire_phy_old;
                tail        <= tail + 1'b1;
            end

            ret_head <= ret_head_next;

            // rewind hands every in-flight register back
            if (ret.flush) begin
                spec_head <= ret_head_next;
            end else if (alloc) begin
                spec_head <= spec_head + 1'b1;
            end
        end
    end

endmodule

/* design/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer import rename_pkg::*; #(
    parameter int PHY_REGS  = 64,
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         alloc,
    input  logic                         has_rd,
    input  arch_reg_t                    rd_arch,
    input  logic [$clog2(PHY_REGS)-1:0]  rd_phy_new,
    input  logic [$clog2(PHY_REGS)-1:0]  rd_phy_old,
    output logic [$clog2(ROB_DEPTH)-1:0] alloc_id,
    output logic                         full,
    input  logic                         complete_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] complete_rob_id,
    input  logic                         complete_mispredict,
    retire_if.rob                        ret
);

    localparam int PHY_W = $clog2(PHY_REGS);
    localparam int ROB_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = ROB_W + 1;

    rob_state_t       state      [ROB_DEPTH];
    logic             ent_has_rd [ROB_DEPTH];
    arch_reg_t        ent_rd     [ROB_DEPTH];
    logic [PHY_W-1:0] ent_new    [ROB_DEPTH];
    logic [PHY_W-1:0] ent_old    [ROB_DEPTH];

    logic [ROB_W-1:0] head;
    logic [ROB_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             retire_now;
    logic             head_mispredict;

    assign alloc_id = tail;
    assign full     = (count == CNT_W'(ROB_DEPTH));

    // head leaves once executed; nothing retires in the flush cycle
    assign head_mispredict = (state[head] == ROB_MISPREDICT);
    assign retire_now = !ret.flush && (state[head] == ROB_DONE || head_mispredict);

    // rename fields only
    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_has_rd[tail] <= has_rd;
            ent_rd[tail]     <= rd_arch;
            ent_new[tail]    <= rd_phy_new;
            ent_old[tail]    <= rd_phy_old;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                state[i] <= ROB_FREE;
            end
            ret.retire_valid   <= 1'b0;
            ret.retire_has_rd  <= 1'b0;
            ret.retire_rd_arch <= '0;
            ret.retire_phy_new <= '0;
            ret.retire_phy_old <= '0;
            ret.flush          <= 1'b0;
        end else begin
            // retire pulses, seen by the consumers one edge later
            ret.retire_valid   <= retire_now;
            ret.retire_has_rd  <= retire_now && ent_has_rd[head];
            ret.retire_rd_arch <= ent_rd[head];
            ret.retire_phy_new <= ent_new[head];
            ret.retire_phy_old <= ent_old[head];
            ret.flush          <= retire_now && head_mispredict;

            if (alloc) begin
                state[tail] <= ROB_ISSUED;
                tail        <= tail + 1'b1;
            end

            if (complete_valid && state[complete_rob_id] == ROB_ISSUED) begin
                state[complete_rob_id] <= complete_mispredict ? ROB_MISPREDICT : ROB_DONE;
            end

            if (retire_now) begin
                state[head] <= ROB_FREE;
                head        <= head + 1'b1;
            end

            count <= count + CNT_W'(alloc) - CNT_W'(retire_now);

            // younger entries are discarded together with the map restore
            if (ret.flush) begin
                head  <= '0;
                tail  <= '0;
                count <= '0;
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    state[i] <= ROB_FREE;
                end
            end
        end
    end

endmodule

/* design/back_rat.sv */
`timescale 1ns/1ps

module back_rat import rename_pkg::*; #(
    parameter int PHY_REGS = 64
) (
    input  logic                                  clk,
    input  logic                                  rst,
    retire_if.sink                                ret,
    output logic [ARCH_REGS*$clog2(PHY_REGS)-1:0] back_table
);

    localparam int PHY_W = $clog2(PHY_REGS);

    // committed map
    logic [PHY_W-1:0] map [ARCH_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= PHY_W'(i);
            end
        end else if (ret.retire_valid && ret.retire_has_rd) begin
            map[ret.retire_rd_arch] <= ret.retire_phy_new;
        end
    end

    // flattened for the flush copy
    always_comb begin
        for (int i = 0; i < ARCH_REGS; i++) begin
            back_table[i*PHY_W +: PHY_W] = map[i];
        end
    end

endmodule

/* design/rename_stage.sv */
`timescale 1ns/1ps

module rename_stage import rename_pkg::*; #(
    parameter int PHY_REGS  = 64,
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         dispatch_valid,
    input  arch_reg_t                    rs1_arch,
    input  arch_reg_t                    rs2_arch,
    input  arch_reg_t                    rd_arch,
    output logic                         dispatch_ready,
    rename_if.stage                      rat,
    input  logic                         fl_empty,
    input  logic [$clog2(PHY_REGS)-1:0]  fl_alloc_phy,
    output logic                         fl_alloc,
    input  logic                         rob_full,
    input  logic [$clog2(ROB_DEPTH)-1:0] rob_alloc_id,
    input  logic                         flush,
    output logic                         rob_alloc,
    output logic                         rob_has_rd,
    output arch_reg_t                    rob_rd_arch,
    output logic [$clog2(PHY_REGS)-1:0]  rob_rd_phy_new,
    output logic [$clog2(PHY_REGS)-1:0]  rob_rd_phy_old,
    output logic                         rename_valid,
    output logic [$clog2(ROB_DEPTH)-1:0] rename_rob_id,
    output logic [$clog2(PHY_REGS)-1:0]  rename_rs1_phy,
    output logic [$clog2(PHY_REGS)-1:0]  rename_rs2_phy,
    output logic [$clog2(PHY_REGS)-1:0]  rename_rd_phy_new,
    output logic [$clog2(PHY_REGS)-1:0]  rename_rd_phy_old
);

    logic accept;
    logic has_rd;

    // level stall
    assign dispatch_ready = !rob_full && !fl_empty && !flush;
    assign accept         = dispatch_valid && dispatch_ready;

    // x0 as destination means no register write
    assign has_rd = (rd_arch != '0);

    assign rat.rs1_arch   = rs1_arch;
    assign rat.rs2_arch   = rs2_arch;
    assign rat.rd_arch    = rd_arch;
    assign rat.rat_we     = accept && has_rd;
    assign rat.rd_phy_new = fl_alloc_phy;

    assign fl_alloc = accept && has_rd;

    assign rob_alloc      = accept;
    assign rob_has_rd     = has_rd;
    assign rob_rd_arch    = rd_arch;
    assign rob_rd_phy_new = has_rd ? fl_alloc_phy : '0;
    assign rob_rd_phy_old = has_rd ? rat.rd_phy_old : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rename_valid <= 1'b0;
        end else begin
            rename_valid <= accept;
        end
    end

    // result held until the next accepted instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            rename_rob_id     <= rob_alloc_id;
            rename_rs1_phy    <= rat.rs1_phy;
            rename_rs2_phy    <= rat.rs2_phy;
            rename_rd_phy_new <= rob_rd_phy_new;
            rename_rd_phy_old <= rob_rd_phy_old;
        end
    end

endmodule

/* design/rename_core.sv */
`timescale 1ns/1ps

module rename_core import rename_pkg::*; #(
    parameter int PHY_REGS  = 64,
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         dispatch_valid,
    input  arch_reg_t                    rs1_arch,
    input  arch_reg_t                    rs2_arch,
    input  arch_reg_t                    rd_arch,
    output logic                         dispatch_ready,
    input  logic                         complete_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] complete_rob_id,
    input  logic                         complete_mispredict,
    output logic                         rename_valid,
    output logic [$clog2(ROB_DEPTH)-1:0] rename_rob_id,
    output logic [$clog2(PHY_REGS)-1:0]  rename_rs1_phy,
    output logic [$clog2(PHY_REGS)-1:0]  rename_rs2_phy,
    output logic [$clog2(PHY_REGS)-1:0]  rename_rd_phy_new,
    output logic [$clog2(PHY_REGS)-1:0]  rename_rd_phy_old,
    output logic                         retire_valid,
    output arch_reg_t                    retire_rd_arch,
    output logic [$clog2(PHY_REGS)-1:0]  retire_phy_new,
    output logic [$clog2(PHY_REGS)-1:0]  retire_phy_old,
    output logic                         flush
);

    localparam int PHY_W = $clog2(PHY_REGS);
    localparam int ROB_W = $clog2(ROB_DEPTH);

    logic                       fl_empty;
    logic                       fl_alloc;
    logic [PHY_W-1:0]           fl_alloc_phy;
    logic                       rob_full;
    logic [ROB_W-1:0]           rob_alloc_id;
    logic                       rob_alloc;
    logic                       rob_has_rd;
    arch_reg_t                  rob_rd_arch;
    logic [PHY_W-1:0]           rob_rd_phy_new;
    logic [PHY_W-1:0]           rob_rd_phy_old;
    logic [ARCH_REGS*PHY_W-1:0] back_table;

    rename_if #(.PHY_REGS(PHY_REGS)) rat_bus ();
    retire_if #(.PHY_REGS(PHY_REGS)) ret_bus ();

    assign retire_valid   = ret_bus.retire_valid;
    assign retire_rd_arch = ret_bus.retire_rd_arch;
    assign retire_phy_new = ret_bus.retire_phy_new;
    assign retire_phy_old = ret_bus.retire_phy_old;
    assign flush          = ret_bus.flush;

    rename_stage #(.PHY_REGS(PHY_REGS), .ROB_DEPTH(ROB_DEPTH)) u_stage (
        .clk               (clk),
        .rst               (rst),
        .dispatch_valid    (dispatch_valid),
        .rs1_arch          (rs1_arch),
        .rs2_arch          (rs2_arch),
        .rd_arch           (rd_arch),
        .dispatch_ready    (dispatch_ready),
        .rat               (rat_bus.stage),
        .fl_empty          (fl_empty),
        .fl_alloc_phy      (fl_alloc_phy),
        .fl_alloc          (fl_alloc),
        .rob_full          (rob_full),
        .rob_alloc_id      (rob_alloc_id),
        .flush             (ret_bus.flush),
        .rob_alloc         (rob_alloc),
        .rob_has_rd        (rob_has_rd),
        .rob_rd_arch       (rob_rd_arch),
        .rob_rd_phy_new    (rob_rd_phy_new),
        .rob_rd_phy_old    (rob_rd_phy_old),
        .rename_valid      (rename_valid),
        .rename_rob_id     (rename_rob_id),
        .rename_rs1_phy    (rename_rs1_phy),
        .rename_rs2_phy    (rename_rs2_phy),
        .rename_rd_phy_new (rename_rd_phy_new),
        .rename_rd_phy_old (rename_rd_phy_old)
    );

    front_rat #(.PHY_REGS(PHY_REGS)) u_front_rat (
        .clk        (clk),
        .rst        (rst),
        .rat        (rat_bus.rat),
        .ret        (ret_bus.sink),
        .back_table (back_table)
    );

    free_list #(.PHY_REGS(PHY_REGS)) u_free_list (
        .clk       (clk),
        .rst       (rst),
        .alloc     (fl_alloc),
        .alloc_phy (fl_alloc_phy),
        .empty     (fl_empty),
        .ret       (ret_bus.sink)
    );

    reorder_buffer #(.PHY_REGS(PHY_REGS), .ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk                 (clk),
        .rst                 (rst),
        .alloc               (rob_alloc),
        .has_rd              (rob_has_rd),
        .rd_arch             (rob_rd_arch),
        .rd_phy_new          (rob_rd_phy_new),
        .rd_phy_old          (rob_rd_phy_old),
        .alloc_id            (rob_alloc_id),
        .full                (rob_full),
        .complete_valid      (complete_valid),
        .complete_rob_id     (complete_rob_id),
        .complete_mispredict (complete_mispredict),
        .ret                 (ret_bus.rob)
    );

    back_rat #(.PHY_REGS(PHY_REGS)) u_back_rat (
        .clk        (clk),
        .rst        (rst),
        .ret        (ret_bus.sink),
        .back_table (back_table)
    );

endmodule

/* dv/rename_core_tb.sv */
`timescale 1ns/1ps

module rename_core_tb import rename_pkg::*; ();

    localparam int PHY_REGS  = 64;
    localparam int ROB_DEPTH = 16;
    localparam int LIMIT     = 500;

    logic                         clk;
    logic                         rst;
    logic                         dispatch_valid;
    arch_reg_t                    rs1_arch;
    arch_reg_t                    rs2_arch;
    arch_reg_t                    rd_arch;
    logic                         dispatch_ready;
    logic                         complete_valid;
    logic [$clog2(ROB_DEPTH)-1:0] complete_rob_id;
    logic                         complete_mispredict;
    logic                         rename_valid;
    logic [$clog2(ROB_DEPTH)-1:0] rename_rob_id;
    logic [$clog2(PHY_REGS)-1:0]  rename_rs1_phy;
    logic [$clog2(PHY_REGS)-1:0]  rename_rs2_phy;
    logic [$clog2(PHY_REGS)-1:0]  rename_rd_phy_new;
    logic [$clog2(PHY_REGS)-1:0]  rename_rd_phy_old;
    logic                         retire_valid;
    arch_reg_t                    retire_rd_arch;
    logic [$clog2(PHY_REGS)-1:0]  retire_phy_new;
    logic [$clog2(PHY_REGS)-1:0]  retire_phy_old;
    logic                         flush;

    // reference model
    int spec_map [ARCH_REGS];
    int ret_map  [ARCH_REGS];
    int free_q [$];
    int inflight_q [$];
    int rob_id_q [$];
    int rob_rd_q [$];
    int rob_new_q [$];
    int rob_old_q [$];
    bit mis_flag [ROB_DEPTH];
    bit done_flag [ROB_DEPTH];
    int rob_tail;
    int issued_q [$];
    // accepted dispatches waiting for their rename output
    int pend_q [$];

    int        errors;
    int        timeouts;
    int        flush_count;
    string     test_name;
    bit        comp_en;
    int        mis_pct;
    bit        force_req;
    bit        force_mis;
    int        force_id;
    arch_reg_t last_rd;
    event      abort_ev;

    rename_core #(.PHY_REGS(PHY_REGS), .ROB_DEPTH(ROB_DEPTH)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic void reset_model();
        for (int i = 0; i < ARCH_REGS; i++) begin
            spec_map[i] = i;
            ret_map[i]  = i;
        end
        for (int i = ARCH_REGS; i < PHY_REGS; i++) begin
            free_q.push_back(i);
        end
        rob_tail = 0;
    endfunction

    function automatic void predict_rename(input int rs1, input int rs2, input int rd,
                                           output int e_id, output int e_rs1,
                                           output int e_rs2, output int e_new,
                                           output int e_old);
        e_id  = rob_tail;
        e_rs1 = spec_map[rs1];
        e_rs2 = spec_map[rs2];
        e_new = 0;
        e_old = 0;
        if (rd != 0) begin
            e_old = spec_map[rd];
            e_new = free_q.pop_front();
            inflight_q.push_back(e_new);
            spec_map[rd] = e_new;
        end
        rob_id_q.push_back(e_id);
        rob_rd_q.push_back(rd);
        rob_new_q.push_back(e_new);
        rob_old_q.push_back(e_old);
        mis_flag[e_id]  = 1'b0;
        done_flag[e_id] = 1'b0;
        rob_tail = (rob_tail + 1) % ROB_DEPTH;
    endfunction

    function automatic void predict_retire(output int e_rd, output int e_new,
                                           output int e_old, output bit e_flush);
        e_flush = mis_flag[rob_id_q.pop_front()];
        e_rd    = rob_rd_q.pop_front();
        e_new   = rob_new_q.pop_front();
        e_old   = rob_old_q.pop_front();
        if (e_rd != 0) begin
            ret_map[e_rd] = e_new;
            void'(inflight_q.pop_front());
            free_q.push_back(e_old);
        end
        // younger work is dropped and its registers go back in front of the free ones
        if (e_flush) begin
            spec_map = ret_map;
            free_q   = {inflight_q, free_q};
            inflight_q.delete();
            rob_id_q.delete();
            rob_rd_q.delete();
            rob_new_q.delete();
            rob_old_q.delete();
            issued_q.delete();
            rob_tail = 0;
        end
    endfunction

    task automatic check_val(input string what, input int exp, input int act);
        assert (exp == act) else begin
            errors++;
            $display("mismatch %s %s expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic report();
        $display("checks done, errors %0d timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    initial begin
        @(abort_ev);
        report();
    end

    // compare outputs mid-cycle where they are stable
    always @(negedge clk) begin : compare
        int  p;
        int  id;
        int  a;
        int  b;
        int  n;
        int  o;
        int  rd;
        bit  ef;
        if (!rst) begin
            if (rename_valid) begin
                assert (pend_q.size() > 0) else begin
                    errors++;
                    $display("rename output seen with no accepted dispatch in %s", test_name);
                end
                if (pend_q.size() > 0) begin
                    p = pend_q.pop_front();
                    predict_rename(p[14:10], p[9:5], p[4:0], id, a, b, n, o);
                    check_val("rob id", id, rename_rob_id);
                    check_val("rs1 phy", a, rename_rs1_phy);
                    check_val("rs2 phy", b, rename_rs2_phy);
                    check_val("rd phy new", n, rename_rd_phy_new);
                    check_val("rd phy old", o, rename_rd_phy_old);
                    issued_q.push_back(id);
                end
            end
            if (retire_valid) begin
                assert (rob_id_q.size() > 0) else begin
                    errors++;
                    $display("retirement seen with no outstanding entry in %s", test_name);
                end
                if (rob_id_q.size() > 0) begin
                    id = rob_id_q[0];
                    assert (done_flag[id]) else begin
                        errors++;
                        $display("ROB entry %0d retired before completion in %s", id, test_name);
                    end
                    predict_retire(rd, n, o, ef);
                    check_val("retire rd", rd, retire_rd_arch);
                    check_val("retire phy new", n, retire_phy_new);
                    check_val("retire phy old", o, retire_phy_old);
                    check_val("flush", ef, flush);
                    if (ef) begin
                        check_val("ready in flush cycle", 0, dispatch_ready);
                    end
                    if (flush) begin
                        flush_count++;
                    end
                end
            end else begin
                check_val("flush without retire", 0, flush);
            end
            if (dispatch_valid && dispatch_ready) begin
                pend_q.push_back({rs1_arch, rs2_arch, rd_arch});
            end
        end
    end

    // execution units complete issued entries in random order
    always @(posedge clk) begin : completer
        int idx;
        int id;
        bit mis;
        bit go;
        go = 1'b0;
        complete_valid      <= 1'b0;
        complete_mispredict <= 1'b0;
        if (force_req) begin
            id        = force_id;
            mis       = force_mis;
            force_req = 1'b0;
            go        = 1'b1;
        end else if (comp_en && issued_q.size() > 0 && $urandom % 2 == 0) begin
            idx = $urandom % issued_q.size();
            id  = issued_q[idx];
            mis = ($urandom % 100) < mis_pct;
            go  = 1'b1;
        end
        if (go) begin
            for (int i = 0; i < issued_q.size(); i++) begin
                if (issued_q[i] == id) begin
                    issued_q.delete(i);
                    break;
                end
            end
            mis_flag[id]        = mis;
            done_flag[id]       = 1'b1;
            complete_valid      <= 1'b1;
            complete_rob_id     <= id;
            complete_mispredict <= mis;
        end
    end

    task automatic set_mode(input bit en, input int pct);
        @(negedge clk);
        comp_en = en;
        mis_pct = pct;
    endtask

    task automatic drive_instr(input bit need_rd);
        arch_reg_t d;
        d = ($urandom % 8 == 0 && !need_rd) ? 5'd0 : arch_reg_t'(1 + $urandom % 31);
        @(posedge clk);
        dispatch_valid <= 1'b1;
        // lean on the previous destination to get back-to-back dependences
        rs1_arch <= ($urandom % 2) ? last_rd : arch_reg_t'($urandom % 32);
        rs2_arch <= arch_reg_t'($urandom % 32);
        rd_arch  <= d;
        if (d != 0) begin
            last_rd = d;
        end
    endtask

    task automatic wait_accept();
        int cnt;
        cnt = 0;
        forever begin
            @(negedge clk);
            if (dispatch_ready) break;
            cnt++;
            if (cnt > LIMIT) begin
                timeouts++;
                $display("timeout waiting for dispatch to be accepted in %s", test_name);
                -> abort_ev;
                break;
            end
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        dispatch_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        forever begin
            @(posedge clk);
            if (rob_id_q.size() == 0 && pend_q.size() == 0) break;
            cnt++;
            if (cnt > LIMIT) begin
                timeouts++;
                $display("timeout waiting for the ROB to drain in %s", test_name);
                -> abort_ev;
                break;
            end
        end
    endtask

    task automatic drain_pending();
        int cnt;
        cnt = 0;
        forever begin
            @(posedge clk);
            if (pend_q.size() == 0) break;
            cnt++;
            if (cnt > LIMIT) begin
                timeouts++;
                $display("timeout waiting for the rename outputs in %s", test_name);
                -> abort_ev;
                break;
            end
        end
    endtask

    task automatic wait_force(input int id, input bit mis);
        int cnt;
        cnt = 0;
        @(negedge clk);
        force_id  = id;
        force_mis = mis;
        force_req = 1'b1;
        forever begin
            @(negedge clk);
            if (!force_req) break;
            cnt++;
            if (cnt > LIMIT) begin
                timeouts++;
                $display("timeout waiting for a completion to be sent in %s", test_name);
                -> abort_ev;
                break;
            end
        end
    endtask

    task automatic run_random(input int n);
        repeat (n) begin
            drive_instr(1'b0);
            wait_accept();
        end
        go_idle();
    endtask

    initial begin
        int  accepted;
        bit  stalled;
        int  prev;
        int  first_id;
        int  second_id;
        void'($urandom(36157));
        rst                 = 1'b1;
        dispatch_valid      = 1'b0;
        rs1_arch            = '0;
        rs2_arch            = '0;
        rd_arch             = '0;
        complete_valid      = 1'b0;
        complete_rob_id     = '0;
        complete_mispredict = 1'b0;
        comp_en             = 1'b0;
        mis_pct             = 0;
        force_req           = 1'b0;
        last_rd             = '0;
        errors              = 0;
        timeouts            = 0;
        flush_count         = 0;
        test_name           = "reset";
        reset_model();
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_val("dispatch_ready", 1, dispatch_ready);
        check_val("rename_valid", 0, rename_valid);
        check_val("retire_valid", 0, retire_valid);
        check_val("flush", 0, flush);

        // identity map first and then dependent chains with random completion
        test_name = "dependent";
        set_mode(1'b1, 0);
        run_random(40);
        wait_drain();

        // no completions until the ROB fills
        test_name = "fill";
        set_mode(1'b0, 0);
        accepted = 0;
        stalled  = 1'b0;
        for (int i = 0; i < ROB_DEPTH + 4 && !stalled; i++) begin
            drive_instr(1'b1);
            @(negedge clk);
            if (dispatch_ready) begin
                accepted++;
            end else begin
                stalled = 1'b1;
            end
        end
        assert (stalled) else begin
            errors++;
            $display("dispatch_ready never dropped with a full ROB");
        end
        check_val("accepted before stall", ROB_DEPTH, accepted);
        set_mode(1'b1, 0);
        wait_accept();
        go_idle();
        wait_drain();

        // mispredict on the second of six
        test_name = "flush";
        set_mode(1'b0, 0);
        repeat (6) begin
            drive_instr(1'b1);
            wait_accept();
        end
        go_idle();
        drain_pending();
        check_val("outstanding entries", 6, rob_id_q.size());
        first_id  = issued_q[0];
        second_id = issued_q[1];
        prev      = flush_count;
        wait_force(second_id, 1'b1);
        wait_force(first_id, 1'b0);
        wait_drain();
        check_val("flush count", prev + 1, flush_count);
        set_mode(1'b1, 0);
        run_random(20);
        wait_drain();

        test_name = "random";
        set_mode(1'b1, 8);
        run_random(300);
        set_mode(1'b1, 0);
        wait_drain();

        report();
    end

endmodule

/* compile.f */
design/rename_pkg.sv
design/rename_if.sv
design/retire_if.sv
design/front_rat.sv
design/free_list.sv
design/reorder_buffer.sv
design/back_rat.sv
design/rename_stage.sv
design/rename_core.sv
dv/rename_core_tb.sv
